// File: logic/boot_ctrl_pkg.sv
`default_nettype none

package boot_ctrl_pkg;

    // boot sequencer states, driven by the FSM and reported in the status word
    typedef enum logic [2:0] {
        BOOT_IDLE   = 3'd0,
        BOOT_FUSE   = 3'd1,
        BOOT_FW_RST = 3'd2,
        BOOT_WAIT   = 3'd3,
        BOOT_DONE   = 3'd4
    } boot_fsm_state_e;

    // default widths of the SoC strobe interface
    localparam int REG_ADDR_W = 4;
    localparam int REG_DATA_W = 32;

    // width of the firmware-update hold counter
    localparam int WAIT_W = 8;

    // register map, word addresses on the strobe interface
    localparam logic [REG_ADDR_W-1:0] ADDR_FUSE_DONE     = 4'h0;
    localparam logic [REG_ADDR_W-1:0] ADDR_FW_UPD_RST    = 4'h1;
    localparam logic [REG_ADDR_W-1:0] ADDR_WAIT_CYCLES   = 4'h2;
    localparam logic [REG_ADDR_W-1:0] ADDR_BOOT_CONTINUE = 4'h3;
    // read only status, see the register block for the bit layout
    localparam logic [REG_ADDR_W-1:0] ADDR_STATUS        = 4'h4;

endpackage

`default_nettype wire

// File: logic/rst_2ff_sync.sv
`timescale 1ns/1ps
`default_nettype none

module rst_2ff_sync #(
    parameter int              WIDTH   = 1,
    parameter logic [WIDTH-1:0] RST_VAL = '0
) (
    input  logic             clk,
    input  logic             rst_b,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    // first stage may go metastable, the second one filters it out
    logic [WIDTH-1:0] meta_q;

    // both stages come up at the reset value so the window reads as asserted
    // until the first clean sample has passed through
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            meta_q <= RST_VAL;
            dout   <= RST_VAL;
        end else begin
            meta_q <= din;
            dout   <= meta_q;
        end
    end

endmodule

`default_nettype wire

// File: logic/boot_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module boot_fsm #(
    parameter int WAIT_W = boot_ctrl_pkg::WAIT_W
) (
    input  logic                          clk,
    input  logic                          cptra_pwrgood,
    input  logic                          cptra_rst_b,
    input  logic                          scan_mode,
    input  logic                          fw_update_rst,
    input  logic [WAIT_W-1:0]             fw_update_rst_wait_cycles,
    input  logic                          boot_brkpoint,
    input  logic                          boot_continue,
    input  logic                          fuse_done,
    input  logic                          fuse_wr_done_observed,
    output boot_ctrl_pkg::boot_fsm_state_e boot_fsm_ps,
    output logic                          ready_for_fuses,
    output logic                          cptra_noncore_rst_b,
    output logic                          cptra_uc_rst_b,
    output logic                          iccm_unlock,
    output logic                          fw_upd_rst_executed,
    output logic                          rdc_clk_dis,
    output logic                          fw_update_rst_window
);

    import boot_ctrl_pkg::*;

    boot_fsm_state_e boot_fsm_ns;

    // reset window, set asynchronously by the warm reset and then synchronized
    logic rst_window;
    logic rst_window_sync;
    logic rst_window_sync_f;
    logic rst_window_sync_2f;

    // per-state requests for the internal resets, before the two output flops
    logic fsm_noncore_rst_b;
    logic fsm_uc_rst_b;
    logic synch_noncore_rst_b;
    logic synch_uc_rst_b;
    logic noncore_rst_b_q;
    logic uc_rst_b_q;

    logic              fsm_iccm_unlock;
    logic [WAIT_W-1:0] wait_count;
    logic              wait_count_load;
    logic              wait_count_decr;

    // warm reset sets the window right away, release is sampled on clk
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            rst_window <= 1'b1;
        end else begin
            rst_window <= 1'b0;
        end
    end

    // window comes up asserted so the FSM stays idle until pwrgood settles
    rst_2ff_sync #(
        .WIDTH   (1),
        .RST_VAL (1'b1)
    ) i_rst_window_sync (
        .clk   (clk),
        .rst_b (cptra_pwrgood),
        .din   (rst_window),
        .dout  (rst_window_sync)
    );

    // clocks of the reset domain are stopped while any copy of the window is set
    // this also covers the two cycles the FSM needs to fall back to idle
    assign rdc_clk_dis = rst_window_sync | rst_window_sync_f | rst_window_sync_2f;

    // core reset may be asserted alone only in these two states
    assign fw_update_rst_window = (boot_fsm_ps == BOOT_FW_RST) || (boot_fsm_ps == BOOT_WAIT);

    always_comb begin
        boot_fsm_ns         = boot_fsm_ps;
        fw_upd_rst_executed = 1'b0;
        fsm_noncore_rst_b   = 1'b1;
        fsm_uc_rst_b        = 1'b0;
        fsm_iccm_unlock     = 1'b0;
        wait_count_load     = 1'b0;
        wait_count_decr     = 1'b0;
        case (boot_fsm_ps)
            BOOT_IDLE: begin
                // the FSM only sits here while the warm reset is active
                fsm_noncore_rst_b = 1'b0;
                if (!rst_window_sync && !rst_window_sync_f && !rst_window_sync_2f) begin
                    boot_fsm_ns = BOOT_FUSE;
                end
            end
            BOOT_FUSE: begin
                // fuse_done alone is sticky over warm reset, so a fresh write
                // since this reset must also have been seen
                if (fuse_done && fuse_wr_done_observed) begin
                    boot_fsm_ns = boot_brkpoint ? BOOT_WAIT : BOOT_DONE;
                end
            end
            BOOT_FW_RST: begin
                // hold the counter at the programmed value until the core reset
                // has made it through the first flop
                wait_count_load = 1'b1;
                if (!synch_uc_rst_b) begin
                    boot_fsm_ns = BOOT_WAIT;
                end
            end
            BOOT_WAIT: begin
                wait_count_decr = 1'b1;
                // a pending breakpoint keeps the core in reset until continue
                if ((wait_count == '0) && !(boot_brkpoint && !boot_continue)) begin
                    boot_fsm_ns = BOOT_DONE;
                    // iccm opens only at the very end of the reset flow
                    fsm_iccm_unlock = 1'b1;
                end
            end
            BOOT_DONE: begin
                fsm_uc_rst_b = 1'b1;
                if (fw_update_rst) begin
                    boot_fsm_ns         = BOOT_FW_RST;
                    fw_upd_rst_executed = 1'b1;
                end
            end
            default: begin
                fsm_noncore_rst_b = 1'b0;
                boot_fsm_ns       = BOOT_IDLE;
            end
        endcase
    end

    // state and reset flops live on the power-good domain
    always_ff @(posedge clk or negedge cptra_pwrgood) begin
        if (!cptra_pwrgood) begin
            boot_fsm_ps         <= BOOT_IDLE;
            rst_window_sync_f   <= 1'b1;
            rst_window_sync_2f  <= 1'b1;
            synch_noncore_rst_b <= 1'b0;
            synch_uc_rst_b      <= 1'b0;
            noncore_rst_b_q     <= 1'b0;
            uc_rst_b_q          <= 1'b0;
        end else begin
            // a synchronized warm reset overrides every arc
            boot_fsm_ps         <= rst_window_sync ? BOOT_IDLE : boot_fsm_ns;
            rst_window_sync_f   <= rst_window_sync;
            rst_window_sync_2f  <= rst_window_sync_f;
            synch_noncore_rst_b <= fsm_noncore_rst_b;
            synch_uc_rst_b      <= fsm_uc_rst_b;
            noncore_rst_b_q     <= synch_noncore_rst_b;
            // core leaves reset only when both requests are released
            uc_rst_b_q          <= synch_noncore_rst_b && synch_uc_rst_b;
        end
    end

    // in scan mode the warm reset pin drives both internal resets
    assign cptra_noncore_rst_b = scan_mode ? cptra_rst_b : noncore_rst_b_q;
    assign cptra_uc_rst_b      = scan_mode ? cptra_rst_b : uc_rst_b_q;

    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            ready_for_fuses <= 1'b0;
            iccm_unlock     <= 1'b0;
            wait_count      <= '0;
        end else begin
            // drops as soon as the SoC has written fuse done in this reset
            ready_for_fuses <= (boot_fsm_ps == BOOT_FUSE) && !fuse_wr_done_observed;
            iccm_unlock     <= fsm_iccm_unlock;
            if (wait_count_decr && (wait_count != '0)) begin
                wait_count <= wait_count - 1'b1;
            end else if (wait_count_load) begin
                wait_count <= fw_update_rst_wait_cycles;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/boot_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module boot_ctrl_regs #(
    parameter int REG_ADDR_W = boot_ctrl_pkg::REG_ADDR_W,
    parameter int REG_DATA_W = boot_ctrl_pkg::REG_DATA_W,
    parameter int WAIT_W     = boot_ctrl_pkg::WAIT_W
) (
    input  logic                          clk,
    input  logic                          cptra_pwrgood,
    input  logic                          cptra_noncore_rst_b,
    input  logic                          reg_wr_en,
    input  logic                          reg_rd_en,
    input  logic [REG_ADDR_W-1:0]         reg_addr,
    input  logic [REG_DATA_W-1:0]         reg_wdata,
    output logic [REG_DATA_W-1:0]         reg_rdata,
    input  boot_ctrl_pkg::boot_fsm_state_e boot_fsm_ps,
    input  logic                          ready_for_fuses,
    input  logic                          iccm_unlock,
    input  logic                          fw_upd_rst_executed,
    output logic                          fuse_done,
    output logic                          fuse_wr_done_observed,
    output logic                          fw_update_rst,
    output logic [WAIT_W-1:0]             fw_update_rst_wait_cycles,
    output logic                          boot_continue
);

    import boot_ctrl_pkg::*;

    logic                  wr_fuse_done;
    logic                  wr_fw_upd_rst;
    logic                  wr_wait_cycles;
    logic                  wr_boot_continue;
    logic                  fw_upd_rst_executed_q;
    logic [REG_DATA_W-1:0] status_word;
    logic [REG_DATA_W-1:0] rd_mux;

    // write strobes per register, only bit 0 matters for the single-bit controls
    assign wr_fuse_done     = reg_wr_en && (reg_addr == REG_ADDR_W'(ADDR_FUSE_DONE));
    assign wr_fw_upd_rst    = reg_wr_en && (reg_addr == REG_ADDR_W'(ADDR_FW_UPD_RST));
    assign wr_wait_cycles   = reg_wr_en && (reg_addr == REG_ADDR_W'(ADDR_WAIT_CYCLES));
    assign wr_boot_continue = reg_wr_en && (reg_addr == REG_ADDR_W'(ADDR_BOOT_CONTINUE));

    // fuse done survives a warm reset, only power-good clears it
    always_ff @(posedge clk or negedge cptra_pwrgood) begin
        if (!cptra_pwrgood) begin
            fuse_done <= 1'b0;
        end else if (wr_fuse_done && reg_wdata[0]) begin
            fuse_done <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            fuse_wr_done_observed     <= 1'b0;
            fw_update_rst             <= 1'b0;
            fw_update_rst_wait_cycles <= WAIT_W'(8);
            boot_continue             <= 1'b0;
            fw_upd_rst_executed_q     <= 1'b0;
        end else begin
            // tells the FSM the SoC has written fuse done since the last reset
            if (wr_fuse_done && reg_wdata[0]) begin
                fuse_wr_done_observed <= 1'b1;
            end
            // request is a single-cycle pulse, the FSM samples it in BOOT_DONE
            fw_update_rst <= wr_fw_upd_rst && reg_wdata[0];
            if (wr_wait_cycles) begin
                fw_update_rst_wait_cycles <= reg_wdata[WAIT_W-1:0];
            end
            if (wr_boot_continue) begin
                boot_continue <= reg_wdata[0];
            end
            // flag stays set until the next noncore reset
            if (fw_upd_rst_executed) begin
                fw_upd_rst_executed_q <= 1'b1;
            end
        end
    end

    // status layout is state in 2:0, then ready, unlock, executed and fuse done
    always_comb begin
        status_word      = '0;
        status_word[2:0] = boot_fsm_ps;
        status_word[4]   = ready_for_fuses;
        status_word[5]   = iccm_unlock;
        status_word[6]   = fw_upd_rst_executed_q;
        status_word[7]   = fuse_done;
    end

    // control registers read back what was written, the update request reads as 0
    always_comb begin
        rd_mux = '0;
        case (reg_addr)
            REG_ADDR_W'(ADDR_FUSE_DONE):     rd_mux[0] = fuse_done;
            REG_ADDR_W'(ADDR_WAIT_CYCLES):   rd_mux[WAIT_W-1:0] = fw_update_rst_wait_cycles;
            REG_ADDR_W'(ADDR_BOOT_CONTINUE): rd_mux[0] = boot_continue;
            REG_ADDR_W'(ADDR_STATUS):        rd_mux = status_word;
            default:                         rd_mux = '0;
        endcase
    end

    // read data shows up the cycle after the strobe and holds until the next read
    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            reg_rdata <= '0;
        end else if (reg_rd_en) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// File: logic/boot_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module boot_ctrl_top (
    input  logic                                 clk,
    input  logic                                 cptra_pwrgood,
    input  logic                                 cptra_rst_b,
    input  logic                                 scan_mode,
    input  logic                                 boot_brkpoint,
    input  logic                                 reg_wr_en,
    input  logic                                 reg_rd_en,
    input  logic [boot_ctrl_pkg::REG_ADDR_W-1:0] reg_addr,
    input  logic [boot_ctrl_pkg::REG_DATA_W-1:0] reg_wdata,
    output logic [boot_ctrl_pkg::REG_DATA_W-1:0] reg_rdata,
    output logic                                 ready_for_fuses,
    output logic                                 cptra_noncore_rst_b,
    output logic                                 cptra_uc_rst_b,
    output logic                                 iccm_unlock,
    output logic                                 rdc_clk_dis,
    output logic                                 fw_update_rst_window
);

    import boot_ctrl_pkg::*;

    // controls from the register block into the sequencer
    logic              fuse_done;
    logic              fuse_wr_done_observed;
    logic              fw_update_rst;
    logic [WAIT_W-1:0] fw_update_rst_wait_cycles;
    logic              boot_continue;

    // sequencer state and the executed pulse go back for status reads
    boot_fsm_state_e   boot_fsm_ps;
    logic              fw_upd_rst_executed;

    // register block runs on the noncore reset it gets from the FSM
    boot_ctrl_regs #(
        .REG_ADDR_W (REG_ADDR_W),
        .REG_DATA_W (REG_DATA_W),
        .WAIT_W     (WAIT_W)
    ) i_boot_ctrl_regs (
        .clk                       (clk),
        .cptra_pwrgood             (cptra_pwrgood),
        .cptra_noncore_rst_b       (cptra_noncore_rst_b),
        .reg_wr_en                 (reg_wr_en),
        .reg_rd_en                 (reg_rd_en),
        .reg_addr                  (reg_addr),
        .reg_wdata                 (reg_wdata),
        .reg_rdata                 (reg_rdata),
        .boot_fsm_ps               (boot_fsm_ps),
        .ready_for_fuses           (ready_for_fuses),
        .iccm_unlock               (iccm_unlock),
        .fw_upd_rst_executed       (fw_upd_rst_executed),
        .fuse_done                 (fuse_done),
        .fuse_wr_done_observed     (fuse_wr_done_observed),
        .fw_update_rst             (fw_update_rst),
        .fw_update_rst_wait_cycles (fw_update_rst_wait_cycles),
        .boot_continue             (boot_continue)
    );

    boot_fsm #(
        .WAIT_W (WAIT_W)
    ) i_boot_fsm (
        .clk                       (clk),
        .cptra_pwrgood             (cptra_pwrgood),
        .cptra_rst_b               (cptra_rst_b),
        .scan_mode                 (scan_mode),
        .fw_update_rst             (fw_update_rst),
        .fw_update_rst_wait_cycles (fw_update_rst_wait_cycles),
        .boot_brkpoint             (boot_brkpoint),
        .boot_continue             (boot_continue),
        .fuse_done                 (fuse_done),
        .fuse_wr_done_observed     (fuse_wr_done_observed),
        .boot_fsm_ps               (boot_fsm_ps),
        .ready_for_fuses           (ready_for_fuses),
        .cptra_noncore_rst_b       (cptra_noncore_rst_b),
        .cptra_uc_rst_b            (cptra_uc_rst_b),
        .iccm_unlock               (iccm_unlock),
        .fw_upd_rst_executed       (fw_upd_rst_executed),
        .rdc_clk_dis               (rdc_clk_dis),
        .fw_update_rst_window      (fw_update_rst_window)
    );

endmodule

`default_nettype wire

// File: verif/boot_ctrl_checker.sv
`timescale 1ns/1ps
`default_nettype none

module boot_ctrl_checker (
    input  logic                                 clk,
    input  logic                                 cptra_pwrgood,
    input  logic                                 cptra_rst_b,
    input  logic                                 scan_mode,
    input  logic                                 boot_brkpoint,
    input  logic                                 reg_wr_en,
    input  logic                                 reg_rd_en,
    input  logic [boot_ctrl_pkg::REG_ADDR_W-1:0] reg_addr,
    input  logic [boot_ctrl_pkg::REG_DATA_W-1:0] reg_wdata,
    input  logic [boot_ctrl_pkg::REG_DATA_W-1:0] reg_rdata,
    input  logic [boot_ctrl_pkg::REG_DATA_W-1:0] exp_rdata,
    input  logic                                 ready_for_fuses,
    input  logic                                 cptra_noncore_rst_b,
    input  logic                                 cptra_uc_rst_b,
    input  logic                                 iccm_unlock,
    input  logic                                 rdc_clk_dis,
    input  logic                                 fw_update_rst_window,
    output int                                   check_count,
    output int                                   error_count
);

    import boot_ctrl_pkg::*;

    // a read strobe from the last edge and the value the testbench expects for it
    logic                  rd_pending;
    logic [REG_DATA_W-1:0] rd_exp;
    logic                  prev_uc;
    logic                  prev_noncore;
    logic                  prev_ready;
    // set while the core is held in reset alone under a live noncore reset
    logic                  in_fw_flow;
    logic                  brk_seen;
    int                    unlock_count;
    int                    low_cycles;
    int                    exp_unlocks;
    // hold count as the SoC last programmed it, tracked from the write strobes
    logic [WAIT_W-1:0]     wait_val;

    initial begin
        check_count = 0;
        error_count = 0;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp, input logic ok);
        check_count = check_count + 1;
        if (!ok) begin
            error_count = error_count + 1;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // everything is sampled on the rising edge, before the testbench drives new values
    always @(posedge clk) begin
        if (cptra_pwrgood) begin
            if (rd_pending) begin
                compare_value("reg_rdata", reg_rdata, rd_exp, reg_rdata === rd_exp);
            end
            if (scan_mode) begin
                // both internal resets simply follow the warm reset pin
                compare_value("cptra_noncore_rst_b", 32'(cptra_noncore_rst_b),
                              32'(cptra_rst_b), cptra_noncore_rst_b === cptra_rst_b);
                compare_value("cptra_uc_rst_b", 32'(cptra_uc_rst_b),
                              32'(cptra_rst_b), cptra_uc_rst_b === cptra_rst_b);
            end else begin
                // fuses are only requested while the core is still held in reset
                if (ready_for_fuses) begin
                    compare_value("cptra_uc_rst_b", 32'(cptra_uc_rst_b), 32'h0,
                                  cptra_uc_rst_b === 1'b0);
                end
                // the reset-domain clocks must already be stopped when noncore drops
                if (prev_noncore && !cptra_noncore_rst_b) begin
                    compare_value("rdc_clk_dis", 32'(rdc_clk_dis), 32'h1, rdc_clk_dis === 1'b1);
                end
                // until the unlock pulse the update window stays open and noncore stays up
                if (in_fw_flow && (unlock_count == 0) && !iccm_unlock) begin
                    compare_value("fw_update_rst_window", 32'(fw_update_rst_window), 32'h1,
                                  fw_update_rst_window === 1'b1);
                    compare_value("cptra_noncore_rst_b", 32'(cptra_noncore_rst_b), 32'h1,
                                  cptra_noncore_rst_b === 1'b1);
                end
                if (!prev_uc && cptra_uc_rst_b) begin
                    // breakpoint and firmware-update releases go through one unlock pulse
                    exp_unlocks = (in_fw_flow || brk_seen) ? 1 : 0;
                    compare_value("ready_for_fuses", 32'(prev_ready), 32'h0, prev_ready === 1'b0);
                    compare_value("iccm_unlock pulses", 32'(unlock_count), 32'(exp_unlocks),
                                  unlock_count == exp_unlocks);
                    if (in_fw_flow) begin
                        compare_value("cptra_uc_rst_b low cycles", 32'(low_cycles),
                                      32'(wait_val), low_cycles >= int'(wait_val));
                    end
                end
            end
        end

        rd_pending   <= reg_rd_en;
        rd_exp       <= exp_rdata;
        prev_uc      <= cptra_uc_rst_b;
        prev_noncore <= cptra_noncore_rst_b;
        prev_ready   <= ready_for_fuses;

        if (!cptra_noncore_rst_b) begin
            in_fw_flow   <= 1'b0;
            brk_seen     <= 1'b0;
            unlock_count <= 0;
            low_cycles   <= 0;
            wait_val     <= WAIT_W'(8);
        end else begin
            if (reg_wr_en && (reg_addr == ADDR_WAIT_CYCLES)) begin
                wait_val <= reg_wdata[WAIT_W-1:0];
            end
            if (prev_uc && !cptra_uc_rst_b) begin
                in_fw_flow   <= 1'b1;
                unlock_count <= 0;
                low_cycles   <= 1;
            end else if (!prev_uc && cptra_uc_rst_b) begin
                in_fw_flow   <= 1'b0;
                brk_seen     <= 1'b0;
                unlock_count <= 0;
            end else begin
                if (iccm_unlock) begin
                    unlock_count <= unlock_count + 1;
                end
                if (!cptra_uc_rst_b) begin
                    low_cycles <= low_cycles + 1;
                end
            end
            if (boot_brkpoint && !cptra_uc_rst_b) begin
                brk_seen <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/boot_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module boot_ctrl_tb;

    import boot_ctrl_pkg::*;

    // kinds of table rows
    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_WAIT  = 2'd2;
    localparam logic [1:0] OP_PIN   = 2'd3;

    // in wait rows the address column picks a DUT output
    localparam logic [3:0] SIG_READY   = 4'd0;
    localparam logic [3:0] SIG_UC      = 4'd1;
    localparam logic [3:0] SIG_NONCORE = 4'd2;
    localparam logic [3:0] SIG_UNLOCK  = 4'd3;
    localparam logic [3:0] SIG_RDC     = 4'd4;
    // in pin rows it picks a DUT input
    localparam logic [3:0] PIN_RST  = 4'd0;
    localparam logic [3:0] PIN_BRK  = 4'd1;
    localparam logic [3:0] PIN_SCAN = 4'd2;

    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        logic [1:0]            op;
        logic [REG_ADDR_W-1:0] addr;
        logic [REG_DATA_W-1:0] data;
        logic [REG_DATA_W-1:0] exp;
    } step_t;

    logic                  clk = 1'b0;
    logic                  cptra_pwrgood;
    logic                  cptra_rst_b;
    logic                  scan_mode;
    logic                  boot_brkpoint;
    logic                  reg_wr_en;
    logic                  reg_rd_en;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [REG_DATA_W-1:0] reg_wdata;
    logic [REG_DATA_W-1:0] reg_rdata;
    logic [REG_DATA_W-1:0] exp_rdata;
    logic                  ready_for_fuses;
    logic                  cptra_noncore_rst_b;
    logic                  cptra_uc_rst_b;
    logic                  iccm_unlock;
    logic                  rdc_clk_dis;
    logic                  fw_update_rst_window;
    int                    check_count;
    int                    error_count;
    int                    timeout_count;
    step_t                 steps[$];

    always #50 clk = ~clk;

    boot_ctrl_top i_boot_ctrl_top (.*);

    // the checker sees the same ports plus the expected read data
    boot_ctrl_checker i_boot_ctrl_checker (.*);

    task automatic add_step(input logic [1:0] op, input logic [REG_ADDR_W-1:0] addr,
                            input logic [REG_DATA_W-1:0] data, input logic [REG_DATA_W-1:0] exp);
        step_t s;
        s.op   = op;
        s.addr = addr;
        s.data = data;
        s.exp  = exp;
        steps.push_back(s);
    endtask

    function automatic logic dut_output(input logic [REG_ADDR_W-1:0] sel);
        case (sel)
            SIG_READY:   return ready_for_fuses;
            SIG_UC:      return cptra_uc_rst_b;
            SIG_NONCORE: return cptra_noncore_rst_b;
            SIG_UNLOCK:  return iccm_unlock;
            default:     return rdc_clk_dis;
        endcase
    endfunction

    function automatic string output_name(input logic [REG_ADDR_W-1:0] sel);
        case (sel)
            SIG_READY:   return "ready_for_fuses";
            SIG_UC:      return "cptra_uc_rst_b";
            SIG_NONCORE: return "cptra_noncore_rst_b";
            SIG_UNLOCK:  return "iccm_unlock";
            default:     return "rdc_clk_dis";
        endcase
    endfunction

    // the write lands on the edge after the strobe is driven
    task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [REG_DATA_W-1:0] data);
        reg_wr_en <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr_en <= 1'b0;
    endtask

    // read data is compared by the checker one edge after the DUT takes the strobe
    task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, input logic [REG_DATA_W-1:0] exp);
        reg_rd_en <= 1'b1;
        reg_addr  <= addr;
        exp_rdata <= exp;
        @(posedge clk);
        reg_rd_en <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_for_output(input logic [REG_ADDR_W-1:0] sel, input logic level);
        int cycles;
        cycles = 0;
        while ((dut_output(sel) !== level) && (cycles < WAIT_LIMIT)) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        if (dut_output(sel) !== level) begin
            timeout_count = timeout_count + 1;
            $display("timeout: %s did not reach %0d within %0d cycles",
                     output_name(sel), level, WAIT_LIMIT);
        end
    endtask

    task automatic set_pin(input logic [REG_ADDR_W-1:0] sel, input logic level);
        case (sel)
            PIN_RST:  cptra_rst_b   <= level;
            PIN_BRK:  boot_brkpoint <= level;
            default:  scan_mode     <= level;
        endcase
        @(posedge clk);
    endtask

    initial begin
        cptra_pwrgood = 1'b0;
        cptra_rst_b   = 1'b0;
        scan_mode     = 1'b0;
        boot_brkpoint = 1'b0;
        reg_wr_en     = 1'b0;
        reg_rd_en     = 1'b0;
        reg_addr      = '0;
        reg_wdata     = '0;
        exp_rdata     = '0;
        timeout_count = 0;

        // cold boot, fuses requested while the core stays in reset
        add_step(OP_WAIT, SIG_READY, 32'h0, 32'h1);
        add_step(OP_READ, ADDR_STATUS, 32'h0, 32'h11);
        // fuse done with no breakpoint releases the core
        add_step(OP_WRITE, ADDR_FUSE_DONE, 32'h1, 32'h0);
        add_step(OP_WAIT, SIG_READY, 32'h0, 32'h0);
        add_step(OP_WAIT, SIG_UC, 32'h0, 32'h1);
        add_step(OP_READ, ADDR_STATUS, 32'h0, 32'h84);
        // warm reset into a breakpoint, continue then unlocks and releases
        add_step(OP_PIN, PIN_BRK, 32'h1, 32'h0);
        add_step(OP_PIN, PIN_RST, 32'h0, 32'h0);
        add_step(OP_WAIT, SIG_NONCORE, 32'h0, 32'h0);
        add_step(OP_PIN, PIN_RST, 32'h1, 32'h0);
        add_step(OP_WAIT, SIG_READY, 32'h0, 32'h1);
        add_step(OP_WRITE, ADDR_FUSE_DONE, 32'h1, 32'h0);
        add_step(OP_WAIT, SIG_READY, 32'h0, 32'h0);
        add_step(OP_READ, ADDR_STATUS, 32'h0, 32'h83);
        add_step(OP_WRITE, ADDR_BOOT_CONTINUE, 32'h1, 32'h0);
        add_step(OP_WAIT, SIG_UNLOCK, 32'h0, 32'h1);
        add_step(OP_WAIT, SIG_UC, 32'h0, 32'h1);
        add_step(OP_PIN, PIN_BRK, 32'h0, 32'h0);
        // firmware-update reset of the core alone with a hold of 20 cycles
        add_step(OP_WRITE, ADDR_WAIT_CYCLES, 32'd20, 32'h0);
        add_step(OP_READ, ADDR_WAIT_CYCLES, 32'h0, 32'h14);
        add_step(OP_WRITE, ADDR_FW_UPD_RST, 32'h1, 32'h0);
        add_step(OP_WAIT, SIG_UC, 32'h0, 32'h0);
        add_step(OP_WAIT, SIG_UNLOCK, 32'h0, 32'h1);
        add_step(OP_WAIT, SIG_UC, 32'h0, 32'h1);
        add_step(OP_READ, ADDR_STATUS, 32'h0, 32'hc4);
        // warm reset keeps fuse done but clears the executed flag
        add_step(OP_PIN, PIN_RST, 32'h0, 32'h0);
        add_step(OP_WAIT, SIG_NONCORE, 32'h0, 32'h0);
        add_step(OP_PIN, PIN_RST, 32'h1, 32'h0);
        add_step(OP_WAIT, SIG_READY, 32'h0, 32'h1);
        add_step(OP_READ, ADDR_STATUS, 32'h0, 32'h91);
        add_step(OP_WRITE, ADDR_FUSE_DONE, 32'h1, 32'h0);
        add_step(OP_WAIT, SIG_READY, 32'h0, 32'h0);
        add_step(OP_WAIT, SIG_UC, 32'h0, 32'h1);
        // scan mode hands both internal resets to the warm reset pin
        add_step(OP_PIN, PIN_SCAN, 32'h1, 32'h0);
        add_step(OP_PIN, PIN_RST, 32'h0, 32'h0);
        add_step(OP_WAIT, SIG_RDC, 32'h0, 32'h1);
        add_step(OP_PIN, PIN_RST, 32'h1, 32'h0);
        add_step(OP_WAIT, SIG_RDC, 32'h0, 32'h0);

        repeat (10) @(posedge clk);
        cptra_pwrgood <= 1'b1;
        cptra_rst_b   <= 1'b1;

        foreach (steps[i]) begin
            case (steps[i].op)
                OP_WRITE: write_reg(steps[i].addr, steps[i].data);
                OP_READ:  read_reg(steps[i].addr, steps[i].exp);
                OP_WAIT:  wait_for_output(steps[i].addr, steps[i].exp[0]);
                default:  set_pin(steps[i].addr, steps[i].data[0]);
            endcase
        end

        repeat (4) @(posedge clk);
        $display("checks %0d, check errors %0d, timeouts %0d",
                 check_count, error_count, timeout_count);
        if ((error_count == 0) && (timeout_count == 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
logic/boot_ctrl_pkg.sv
logic/rst_2ff_sync.sv
logic/boot_fsm.sv
logic/boot_ctrl_regs.sv
logic/boot_ctrl_top.sv
verif/boot_ctrl_checker.sv
verif/boot_ctrl_tb.sv

// File: Makefile
# Verilator build and run of the boot controller testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f compile.f --top-module boot_ctrl_tb -Mdir obj_dir
	./obj_dir/Vboot_ctrl_tb | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
